/* logic/image_read_pkg.sv */
// shared definitions of the image read path
// config bus widths, register addresses and the working configuration struct

`default_nettype none

package image_read_pkg;

    // config bus
    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // register map
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_IMG_W  = 5'h04; // width in the lower half
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_IMG_DH = 5'h05; // depth [31:16], height [15:0]
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_PAD    = 5'h06; // left, right, top, bottom bytes
    localparam logic [CFG_AWIDTH-1:0] CFG_IR_CONV   = 5'h07; // maxp side, conv side, step

    // configuration of one pass, staged by config writes and latched on next
    typedef struct packed {
        logic [15:0] img_w;     // image width in pixels
        logic [15:0] img_h;     // image height
        logic [15:0] img_d;     // depth in words per pixel position
        logic [7:0]  pad_l;     // padding columns on the left
        logic [7:0]  pad_r;     // padding columns on the right
        logic [7:0]  pad_t;     // padding rows on top
        logic [7:0]  pad_b;     // padding rows at the bottom
        logic [7:0]  maxp_side; // maxpool side, stored only
        logic [7:0]  conv_side; // kernel side, e.g. 3 for 3x3
        logic [15:0] conv_step; // distance between windows
    } win_cfg_t;

endpackage

`default_nettype wire

/* logic/image_read_if.sv */
// internal interfaces of the image read path
// win_ctrl_if carries the pass configuration, rd_req_if the read requests

`timescale 1ns/1ps
`default_nettype none

interface win_ctrl_if;
    image_read_pkg::win_cfg_t cfg;  // working copy, stable during a pass
    logic                     start; // one-cycle pulse, begins a pass
    logic                     done;  // one-cycle pulse after the final request

    modport ctrl (output cfg, output start, input done);
    modport gen (input cfg, input start, output done);
endinterface

interface rd_req_if #(
    parameter int MEM_AWIDTH = 10
);
    logic                  val;    // request moves on every cycle it is high
    logic [MEM_AWIDTH-1:0] addr;   // word address in image memory
    logic                  pad;    // padding position, no read, zero word
    logic                  last;   // final word of a window
    logic                  credit; // aligner has room for all words in flight

    modport src (output val, output addr, output pad, output last, input credit);
    modport mem (input val, input addr, input pad);
    modport sink (input val, input pad, input last, output credit);
endinterface

`default_nettype wire

/* logic/image_read_ctrl.sv */
// config register decode, working copy on next and the idle/busy sequence

`timescale 1ns/1ps
`default_nettype none

module image_read_ctrl (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire [image_read_pkg::CFG_DWIDTH-1:0]    cfg_data,
    input  wire [image_read_pkg::CFG_AWIDTH-1:0]    cfg_addr,
    input  wire                                     cfg_valid,
    input  wire                                     next,
    output logic                                    busy,
    win_ctrl_if.ctrl                                win,
    input  wire                                     drained
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t                   state;
    image_read_pkg::win_cfg_t staged;    // written by the config bus at any time
    logic                     done_seen; // generator finished, words may still drain
    logic                     accept;

    assign accept = next & (state == ST_IDLE); // next ignored during a pass
    assign busy   = (state == ST_BUSY);

    // staged registers, same field layout as the register map
    always_ff @(posedge clk) begin
        if (cfg_valid) begin
            case (cfg_addr)
                image_read_pkg::CFG_IR_IMG_W: begin
                    staged.img_w <= cfg_data[15:0]; // upper half ignored
                end
                image_read_pkg::CFG_IR_IMG_DH: begin
                    staged.img_d <= cfg_data[31:16];
                    staged.img_h <= cfg_data[15:0];
                end
                image_read_pkg::CFG_IR_PAD: begin
                    staged.pad_l <= cfg_data[31:24];
                    staged.pad_r <= cfg_data[23:16];
                    staged.pad_t <= cfg_data[15:8];
                    staged.pad_b <= cfg_data[7:0];
                end
                image_read_pkg::CFG_IR_CONV: begin
                    staged.maxp_side <= cfg_data[31:24];
                    staged.conv_side <= cfg_data[23:16];
                    staged.conv_step <= cfg_data[15:0];
                end
                default: ;
            endcase
        end
    end

    // working copy only changes on an accepted next
    always_ff @(posedge clk) begin
        if (accept) begin
            win.cfg <= staged;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            win.start <= 1'b0;
            done_seen <= 1'b0;
        end else begin
            win.start <= accept; // start and busy rise together
            case (state)
                ST_IDLE: begin
                    done_seen <= 1'b0;
                    if (accept) state <= ST_BUSY;
                end
                ST_BUSY: begin
                    if (win.done) done_seen <= 1'b1;
                    // pass ends once every word has left the aligner
                    if ((done_seen | win.done) & drained) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/image_addr_gen.sv */
// window walk over the padded image
// issues one read or pad request per cycle while the aligner gives credit

`timescale 1ns/1ps
`default_nettype none

module image_addr_gen #(
    parameter int MEM_AWIDTH = 10
) (
    input  wire     clk,
    input  wire     rst_n,
    win_ctrl_if.gen win,
    rd_req_if.src   req
);

    logic        running;
    logic [15:0] oy;        // output row origin in padded space
    logic [15:0] ox;        // output column origin
    logic [15:0] ky;        // kernel row
    logic [15:0] kx;        // kernel column
    logic [15:0] di;        // depth index
    logic [16:0] pw;        // padded width
    logic [16:0] ph;        // padded height
    logic [16:0] py;
    logic [16:0] px;
    logic [16:0] iy;        // image row once the top pad is removed
    logic [16:0] ix;
    logic [31:0] pix;       // pixel index inside the image
    logic [47:0] lin;       // word index before truncation
    logic        pad_y;
    logic        pad_x;
    logic        last_d;
    logic        last_kx;
    logic        last_ky;
    logic        last_ox;
    logic        last_oy;
    logic        final_word;

    assign pw = 17'(win.cfg.img_w) + 17'(win.cfg.pad_l) + 17'(win.cfg.pad_r);
    assign ph = 17'(win.cfg.img_h) + 17'(win.cfg.pad_t) + 17'(win.cfg.pad_b);

    assign py = 17'(oy) + 17'(ky);
    assign px = 17'(ox) + 17'(kx);
    assign iy = py - 17'(win.cfg.pad_t);
    assign ix = px - 17'(win.cfg.pad_l);

    assign pad_y = (py < 17'(win.cfg.pad_t)) |
                   (py >= 17'(win.cfg.pad_t) + 17'(win.cfg.img_h));
    assign pad_x = (px < 17'(win.cfg.pad_l)) |
                   (px >= 17'(win.cfg.pad_l) + 17'(win.cfg.img_w));

    // (row * width + col) * depth + depth index
    assign pix = 32'(iy[15:0]) * 32'(win.cfg.img_w) + 32'(ix[15:0]);
    assign lin = 48'(pix) * 48'(win.cfg.img_d) + 48'(di);

    assign last_d  = (di == win.cfg.img_d - 16'd1);
    assign last_kx = (kx == 16'(win.cfg.conv_side) - 16'd1);
    assign last_ky = (ky == 16'(win.cfg.conv_side) - 16'd1);
    // next window would no longer fit inside the padded extent
    assign last_ox = (18'(ox) + 18'(win.cfg.conv_step) + 18'(win.cfg.conv_side)) > 18'(pw);
    assign last_oy = (18'(oy) + 18'(win.cfg.conv_step) + 18'(win.cfg.conv_side)) > 18'(ph);
    assign final_word = last_d & last_kx & last_ky & last_ox & last_oy;

    assign req.val  = running & req.credit; // counters hold without credit
    assign req.addr = lin[MEM_AWIDTH-1:0];
    assign req.pad  = pad_y | pad_x;
    assign req.last = last_d & last_kx & last_ky;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            win.done <= 1'b0;
            oy       <= '0;
            ox       <= '0;
            ky       <= '0;
            kx       <= '0;
            di       <= '0;
        end else begin
            win.done <= req.val & final_word;
            if (win.start) begin
                running <= 1'b1;
                oy      <= '0;
                ox      <= '0;
                ky      <= '0;
                kx      <= '0;
                di      <= '0;
            end else if (req.val) begin
                if (final_word) running <= 1'b0;
                // depth, then kernel column, kernel row, output column, output row
                if (!last_d) begin
                    di <= di + 16'd1;
                end else begin
                    di <= '0;
                    if (!last_kx) begin
                        kx <= kx + 16'd1;
                    end else begin
                        kx <= '0;
                        if (!last_ky) begin
                            ky <= ky + 16'd1;
                        end else begin
                            ky <= '0;
                            if (!last_ox) begin
                                ox <= ox + win.cfg.conv_step;
                            end else begin
                                ox <= '0;
                                oy <= oy + win.cfg.conv_step;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/image_mem.sv */
// image memory, one word of GROUP_NB pixels per address
// synchronous read followed by RD_LATENCY-1 output registers

`timescale 1ns/1ps
`default_nettype none

module image_mem #(
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int MEM_AWIDTH = 10,
    parameter int RD_LATENCY = 3
) (
    input  wire                              clk,
    input  wire                              wr_en,
    input  wire  [MEM_AWIDTH-1:0]            wr_addr,
    input  wire  [GROUP_NB*IMG_WIDTH-1:0]    wr_data,
    rd_req_if.mem                            req,
    output logic [GROUP_NB*IMG_WIDTH-1:0]    rd_data
);

    localparam int WORD_W = GROUP_NB * IMG_WIDTH;

    logic [WORD_W-1:0] ram [2**MEM_AWIDTH];
    logic [WORD_W-1:0] rd_q [RD_LATENCY];  // stage 0 is the ram output

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
        if (req.val & ~req.pad) begin // pad positions skip the read
            rd_q[0] <= ram[req.addr];
        end
        for (int i = 1; i < RD_LATENCY; i++) begin
            rd_q[i] <= rd_q[i-1];
        end
    end

    assign rd_data = rd_q[RD_LATENCY-1];

endmodule

`default_nettype wire

/* logic/image_pad_align.sv */
// tag line matched to the memory latency, zero substitution for pad words
// and an output FIFO with credit back to the generator

`timescale 1ns/1ps
`default_nettype none

module image_pad_align #(
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int RD_LATENCY = 3
) (
    input  wire                             clk,
    input  wire                             rst_n,
    rd_req_if.sink                          req,
    input  wire  [GROUP_NB*IMG_WIDTH-1:0]   rd_data,
    output logic [GROUP_NB*IMG_WIDTH-1:0]   image_bus,
    output logic                            image_last,
    output logic                            image_val,
    input  wire                             image_rdy,
    output logic                            drained
);

    localparam int WORD_W = GROUP_NB * IMG_WIDTH;
    localparam int DEPTH  = RD_LATENCY + 2;
    localparam int PW     = $clog2(DEPTH);
    localparam int CW     = $clog2(DEPTH + 1);
    localparam logic [RD_LATENCY-1:0] EARLY = ~(RD_LATENCY'(1) << (RD_LATENCY - 1));

    logic [RD_LATENCY-1:0] tag_val;   // stage i holds requests issued i+1 cycles ago
    logic [RD_LATENCY-1:0] tag_pad;
    logic [RD_LATENCY-1:0] tag_last;
    logic [WORD_W:0]       fifo_q [DEPTH]; // {last, word}
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [CW-1:0]         count;
    logic [CW-1:0]         count_nxt;
    logic [CW-1:0]         inflight;
    logic [WORD_W:0]       push_word;
    logic                  push;
    logic                  pop;
    logic                  store;
    logic                  pop_fifo;

    assign push      = tag_val[RD_LATENCY-1];
    assign push_word = {tag_last[RD_LATENCY-1], tag_pad[RD_LATENCY-1] ? '0 : rd_data};

    // empty FIFO passes the arriving word straight through
    assign image_val                = (count != '0) | push;
    assign {image_last, image_bus}  = (count != '0) ? fifo_q[rd_ptr] : push_word;

    assign pop      = image_val & image_rdy;
    assign pop_fifo = pop & (count != '0);
    assign store    = push & ~(pop & (count == '0));
    assign count_nxt = count + CW'(store) - CW'(pop_fifo);

    always_comb begin
        inflight = '0;
        for (int i = 0; i < RD_LATENCY; i++) begin
            inflight = inflight + CW'(tag_val[i]);
        end
    end

    // room for every word that could still arrive, plus one issued now
    assign req.credit = (CW'(count) + inflight) < CW'(DEPTH);
    assign drained    = ~req.val & ((tag_val & EARLY) == '0) & (count_nxt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_val <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            tag_val <= RD_LATENCY'({tag_val, req.val});
            if (store) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            if (pop_fifo) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            count <= count_nxt;
        end
    end

    always_ff @(posedge clk) begin
        tag_pad  <= RD_LATENCY'({tag_pad, req.pad});
        tag_last <= RD_LATENCY'({tag_last, req.last});
        if (store) begin
            fifo_q[wr_ptr] <= push_word;
        end
    end

endmodule

`default_nettype wire

/* logic/image_read_top.sv */
// top level of the image read path
// control, window address generator, image memory and pad aligner

`timescale 1ns/1ps
`default_nettype none

module image_read_top #(
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int MEM_AWIDTH = 10,
    parameter int RD_LATENCY = 3
) (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire  [image_read_pkg::CFG_DWIDTH-1:0]   cfg_data,
    input  wire  [image_read_pkg::CFG_AWIDTH-1:0]   cfg_addr,
    input  wire                                     cfg_valid,
    input  wire                                     next,
    input  wire                                     mem_wr_en,
    input  wire  [MEM_AWIDTH-1:0]                   mem_wr_addr,
    input  wire  [GROUP_NB*IMG_WIDTH-1:0]           mem_wr_data,
    input  wire                                     image_rdy,
    output logic [GROUP_NB*IMG_WIDTH-1:0]           image_bus,
    output logic                                    image_last,
    output logic                                    image_val,
    output logic                                    busy
);

    logic                          drained; // aligner holds no words
    logic [GROUP_NB*IMG_WIDTH-1:0] rd_data;

    win_ctrl_if                          win ();
    rd_req_if #(.MEM_AWIDTH(MEM_AWIDTH)) req ();

    image_read_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_data  (cfg_data),
        .cfg_addr  (cfg_addr),
        .cfg_valid (cfg_valid),
        .next      (next),
        .busy      (busy),
        .win       (win.ctrl),
        .drained   (drained)
    );

    image_addr_gen #(.MEM_AWIDTH(MEM_AWIDTH)) u_addr_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .win   (win.gen),
        .req   (req.src)
    );

    image_mem #(
        .GROUP_NB   (GROUP_NB),
        .IMG_WIDTH  (IMG_WIDTH),
        .MEM_AWIDTH (MEM_AWIDTH),
        .RD_LATENCY (RD_LATENCY)
    ) u_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .req     (req.mem),
        .rd_data (rd_data)
    );

    image_pad_align #(
        .GROUP_NB   (GROUP_NB),
        .IMG_WIDTH  (IMG_WIDTH),
        .RD_LATENCY (RD_LATENCY)
    ) u_pad_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req.sink),
        .rd_data    (rd_data),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .drained    (drained)
    );

endmodule

`default_nettype wire

/* verification/image_read_assertions.sv */
// protocol checks bound to the image read top level
// output stream hold and stability, reset state, requests only with buffer room

`timescale 1ns/1ps
`default_nettype none

module image_read_assertions #(
    parameter int WORD_W     = 64,
    parameter int RD_LATENCY = 3
) (
    input wire              clk,
    input wire              rst_n,
    input wire              image_val,
    input wire              image_rdy,
    input wire [WORD_W-1:0] image_bus,
    input wire              image_last,
    input wire              busy,
    input wire              req_val
);

    int outstanding; // requests issued and not yet accepted at the output

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_val) - int'(image_val && image_rdy);
        end
    end

    // a stalled word stays offered
    val_hold: assert property (@(posedge clk) disable iff (!rst_n)
        image_val && !image_rdy |=> image_val)
        else $error("image_val dropped before the word was accepted");

    bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        image_val && !image_rdy |=> $stable(image_bus) && $stable(image_last))
        else $error("image_bus or image_last changed while stalled");

    busy_reset: assert property (@(posedge clk) !rst_n |-> !busy && !image_val)
        else $error("busy or image_val high during reset");

    // aligner buffer holds RD_LATENCY + 2 words, a new request needs a free slot
    credit_only: assert property (@(posedge clk) disable iff (!rst_n)
        req_val |-> outstanding < RD_LATENCY + 2)
        else $error("read request issued without room in the aligner buffer");

endmodule

`default_nettype wire

/* verification/tb_image_read.sv */
// testbench for the image read path
// memory load, tests from the data file, window walk model and compare tasks

`timescale 1ns/1ps
`default_nettype none

module tb_image_read;

    localparam int GROUP_NB   = 4;
    localparam int IMG_WIDTH  = 16;
    localparam int MEM_AWIDTH = 10;
    localparam int RD_LATENCY = 3;
    localparam int MAX_TESTS  = 16;

    typedef logic [GROUP_NB*IMG_WIDTH-1:0] word_t;

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data;
    logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr;
    logic                                  cfg_valid;
    logic                                  next;
    logic                                  mem_wr_en;
    logic [MEM_AWIDTH-1:0]                 mem_wr_addr;
    word_t                                 mem_wr_data;
    logic                                  image_rdy = 1'b0;
    word_t                                 image_bus;
    logic                                  image_last;
    logic                                  image_val;
    logic                                  busy;

    string       test_name  [MAX_TESTS];
    int          test_mode  [MAX_TESTS];    // 0 plain, 1 random stall, 2 staged in previous pass
    logic [31:0] test_cfg   [MAX_TESTS][4]; // width, depth/height, pads, conv
    int          test_words [MAX_TESTS];
    int          test_wins  [MAX_TESTS];
    int          n_tests;
    word_t       exp_word [$];
    logic        exp_last [$];
    int          errors;
    int          rx_count;                  // words accepted in the running pass
    int          limit;                     // watchdog cycles
    bit          counting;
    bit          stall_en;

    image_read_top #(
        .GROUP_NB   (GROUP_NB),
        .IMG_WIDTH  (IMG_WIDTH),
        .MEM_AWIDTH (MEM_AWIDTH),
        .RD_LATENCY (RD_LATENCY)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_data    (cfg_data),
        .cfg_addr    (cfg_addr),
        .cfg_valid   (cfg_valid),
        .next        (next),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .image_rdy   (image_rdy),
        .image_bus   (image_bus),
        .image_last  (image_last),
        .image_val   (image_val),
        .busy        (busy)
    );

    bind image_read_top image_read_assertions #(
        .WORD_W     (GROUP_NB * IMG_WIDTH),
        .RD_LATENCY (RD_LATENCY)
    ) u_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .image_bus  (image_bus),
        .image_last (image_last),
        .busy       (busy),
        .req_val    (req.val)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        if (stall_en) image_rdy <= 1'($urandom % 2); // random back-pressure
        else image_rdy <= 1'b1;
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (counting);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the pass did not finish within %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // pixel g of word a, never zero so pad words stand out
    function automatic word_t pattern_word(input int a);
        word_t w;
        for (int g = 0; g < GROUP_NB; g++) begin
            w[g*IMG_WIDTH +: IMG_WIDTH] = IMG_WIDTH'(a * GROUP_NB + g + 1);
        end
        return w;
    endfunction

    task automatic note_error(input string name, input string msg);
        $display("error in %0s: %0s", name, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input int idx, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0s word %0d: expected %h actual %h", name, idx, exp, act);
            errors++;
        end
    endtask

    task automatic check_last(input string name, input int idx, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0s image_last %0d: expected %b actual %b", name, idx, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0s %0s: expected %0d actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic read_tests();
        int          fd;
        string       line;
        string       nm;
        int          md;
        int          nw;
        int          nwin;
        logic [31:0] c0, c1, c2, c3;
        n_tests = 0;
        fd = $fopen("verification/image_read_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/image_read_tests.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.substr(0, 0) == "#") continue; // comment line
                if ($sscanf(line, "%s %d %h %h %h %h %d %d",
                            nm, md, c0, c1, c2, c3, nw, nwin) == 8) begin
                    test_name[n_tests]   = nm;
                    test_mode[n_tests]   = md;
                    test_cfg[n_tests][0] = c0;
                    test_cfg[n_tests][1] = c1;
                    test_cfg[n_tests][2] = c2;
                    test_cfg[n_tests][3] = c3;
                    test_words[n_tests]  = nw;
                    test_wins[n_tests]   = nwin;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < 2**MEM_AWIDTH; a++) begin
            @(posedge clk);
            mem_wr_en   <= 1'b1;
            mem_wr_addr <= MEM_AWIDTH'(a);
            mem_wr_data <= pattern_word(a);
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    task automatic write_config(input int t);
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            cfg_valid <= 1'b1;
            cfg_addr  <= (k == 0) ? image_read_pkg::CFG_IR_IMG_W :
                         (k == 1) ? image_read_pkg::CFG_IR_IMG_DH :
                         (k == 2) ? image_read_pkg::CFG_IR_PAD : image_read_pkg::CFG_IR_CONV;
            cfg_data  <= test_cfg[t][k];
        end
        @(posedge clk);
        cfg_valid <= 1'b0;
    endtask

    task automatic pulse_next();
        @(posedge clk);
        next <= 1'b1;
        @(posedge clk);
        next <= 1'b0; // dut samples next on this edge
    endtask

    // window walk: output row, output column, kernel row, kernel column, depth
    task automatic build_expected(input int t);
        int w, h, d, pl, pr, pt, pb, side, step, py, px;
        w    = int'(test_cfg[t][0][15:0]);
        d    = int'(test_cfg[t][1][31:16]);
        h    = int'(test_cfg[t][1][15:0]);
        pl   = int'(test_cfg[t][2][31:24]);
        pr   = int'(test_cfg[t][2][23:16]);
        pt   = int'(test_cfg[t][2][15:8]);
        pb   = int'(test_cfg[t][2][7:0]);
        side = int'(test_cfg[t][3][23:16]);
        step = int'(test_cfg[t][3][15:0]);
        exp_word.delete();
        exp_last.delete();
        for (int oy = 0; oy + side <= h + pt + pb; oy += step) begin
            for (int ox = 0; ox + side <= w + pl + pr; ox += step) begin
                for (int ky = 0; ky < side; ky++) begin
                    for (int kx = 0; kx < side; kx++) begin
                        for (int di = 0; di < d; di++) begin
                            py = oy + ky;
                            px = ox + kx;
                            if (py < pt || py >= pt + h || px < pl || px >= pl + w) begin
                                exp_word.push_back('0); // padding gives a zero word
                            end else begin
                                exp_word.push_back(pattern_word(
                                    (((py - pt) * w + (px - pl)) * d + di) % (2**MEM_AWIDTH)));
                            end
                            exp_last.push_back(ky == side - 1 && kx == side - 1 && di == d - 1);
                        end
                    end
                end
            end
        end
    endtask

    task automatic collect_pass(input int t, output int nwin);
        int edge_no;
        int last_edge;
        bit finished;
        nwin      = 0;
        edge_no   = 0;
        last_edge = -1;
        finished  = 1'b0;
        @(posedge clk);
        if (!busy) note_error(test_name[t], "busy did not rise on the cycle after next");
        while (!finished) begin
            @(posedge clk);
            edge_no++;
            if (!busy) begin
                finished = 1'b1;
                if (image_val) note_error(test_name[t], "image_val still high after busy fell");
                if (last_edge != edge_no - 1) begin
                    note_error(test_name[t], "busy did not fall on the cycle after the last word");
                end
            end else if (image_val && image_rdy) begin
                if (rx_count < exp_word.size()) begin
                    check_word(test_name[t], rx_count, exp_word[rx_count], image_bus);
                    check_last(test_name[t], rx_count, exp_last[rx_count], image_last);
                end else begin
                    note_error(test_name[t], "extra word after the end of the pass");
                end
                nwin += int'(image_last);
                rx_count++;
                last_edge = edge_no;
            end
        end
    endtask

    // stage the following test's config and try a second next while busy
    task automatic reconfigure_mid_pass(input int t);
        if (t + 1 < n_tests && test_mode[t + 1] == 2) begin
            wait (rx_count >= 10);
            write_config(t + 1);
            pulse_next();
            if (!busy) note_error(test_name[t], "pass ended before the second next arrived");
        end
    endtask

    task automatic run_test(input int t, output bit ok);
        int nwin;
        int errs_before;
        errs_before = errors;
        if (test_mode[t] != 2) write_config(t); // mode 2 was staged during the last pass
        build_expected(t);
        stall_en <= (test_mode[t] == 1);
        rx_count = 0;
        pulse_next();
        fork
            collect_pass(t, nwin);
            reconfigure_mid_pass(t);
        join
        stall_en <= 1'b0;
        check_count(test_name[t], "words", test_words[t], rx_count);
        check_count(test_name[t], "windows", test_wins[t], nwin);
        ok = (errors == errs_before);
        $display("test %0s: %0d words, %0d windows, %0s",
                 test_name[t], rx_count, nwin, ok ? "ok" : "mismatch");
    endtask

    initial begin
        int seed;
        int n_pass;
        bit ok;
        seed        = $urandom(32'h41ba);
        rst_n       <= 1'b0;
        cfg_data    <= '0;
        cfg_addr    <= '0;
        cfg_valid   <= 1'b0;
        next        <= 1'b0;
        mem_wr_en   <= 1'b0;
        mem_wr_addr <= '0;
        mem_wr_data <= '0;
        errors      = 0;
        n_pass      = 0;
        counting    = 1'b0;
        stall_en    = 1'b0;
        rx_count    = 0;
        read_tests();
        if (n_tests == 0) note_error("setup", "no test lines found in the tests file");
        limit = 200;
        for (int t = 0; t < n_tests; t++) limit += test_words[t] * 8;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (busy || image_val) note_error("reset", "busy or image_val high after reset");
        load_memory();
        counting = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t, ok);
            if (ok) n_pass++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, n_pass, n_tests - n_pass, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/image_read_tests.txt */
# name mode img_w img_dh pad conv words windows (config words in hex)
# mode 0 plain, 1 random image_rdy stall, 2 config written during the previous pass
nopad_3x3     0 00000006 00010006 00000000 02030001 144 16
pad_all       0 00000005 00020004 01010101 02030001 360 20
step2_depth3  0 abcd0007 00030005 00000000 00030002 162 6
pad_all_stall 1 00000005 00020004 01010101 02030001 360 20
mid_pass_cfg  0 00000008 00010006 02000100 02030002 108 12
staged_next   2 00000004 00020004 00000202 02040004 64 2

/* image_read.f */
logic/image_read_pkg.sv
logic/image_read_if.sv
logic/image_read_ctrl.sv
logic/image_addr_gen.sv
logic/image_mem.sv
logic/image_pad_align.sv
logic/image_read_top.sv
verification/image_read_assertions.sv
verification/tb_image_read.sv

/* Makefile */
# Verilator build and run of the image read testbench

VERILATOR ?= verilator
TOP       ?= tb_image_read
FILELIST  ?= image_read.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
